// File: hw/conv_pkg.sv
package conv_pkg;

	// data widths
	localparam int PIXEL_W = 8;
	localparam int COEF_W = 8;

	// 9 x 255 x 128 plus a bias still fits in 20 signed bits
	localparam int ACC_W = 20;

	// 3x3 kernel
	localparam int KERNEL_TAPS = 9;

	// row and column index width
	localparam int POS_W = 8;

	// pixels are unsigned
	typedef logic [PIXEL_W-1:0] pixel_t;

	// weights and biases are signed
	typedef logic signed [COEF_W-1:0] coef_t;

	// per-channel convolution result
	typedef logic signed [ACC_W-1:0] acc_t;

	typedef logic [POS_W-1:0] pos_t;

	// weights come first in the coefficient stream, then biases
	typedef enum logic [1:0]
	{
		LOAD_WEIGHTS = 2'd0,
		LOAD_BIAS    = 2'd1,
		LOADED       = 2'd2
	} load_state_t;

endpackage

// File: hw/coef_loader.sv
`timescale 1ns/100ps

module coef_loader #(
	parameter int CH_NUM = 2
)(
	input  logic                                                  clk,
	input  logic                                                  rst,
	input  logic                                                  coef_req,
	input  conv_pkg::coef_t                                       coef_data,
	output logic                                                  coef_ack,
	output logic                                                  coef_ready,
	output logic [CH_NUM*conv_pkg::KERNEL_TAPS*conv_pkg::COEF_W-1:0] weights,
	output logic [CH_NUM*conv_pkg::COEF_W-1:0]                      biases
);
	localparam int N_WEIGHTS = CH_NUM * conv_pkg::KERNEL_TAPS;
	localparam int CNT_W = $clog2(N_WEIGHTS + 1);

	conv_pkg::load_state_t state;
	logic [CNT_W-1:0]      tap_cnt;
	logic                  capture;
	conv_pkg::coef_t       weight_reg [N_WEIGHTS];
	conv_pkg::coef_t       bias_reg [CH_NUM];

	// new word on the rising half of the handshake
	assign capture = coef_req && !coef_ack && (state != conv_pkg::LOADED);
	assign coef_ready = (state == conv_pkg::LOADED);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= conv_pkg::LOAD_WEIGHTS;
			tap_cnt <= '0;
			coef_ack <= 1'b0;
		end
		else
		begin
			if (capture)
				coef_ack <= 1'b1;
			else if (!coef_req)
				coef_ack <= 1'b0;

			if (capture)
			begin
				case (state)
				conv_pkg::LOAD_WEIGHTS:
				begin
					if (tap_cnt == CNT_W'(N_WEIGHTS - 1))
					begin
						state <= conv_pkg::LOAD_BIAS;
						tap_cnt <= '0;
					end
					else
						tap_cnt <= tap_cnt + 1'b1;
				end
				conv_pkg::LOAD_BIAS:
				begin
					if (tap_cnt == CNT_W'(CH_NUM - 1))
						state <= conv_pkg::LOADED;
					else
						tap_cnt <= tap_cnt + 1'b1;
				end
				default:
					state <= state;
				endcase
			end
		end
	end

	// shift chains, first word ends up at index 0
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < N_WEIGHTS; i++)
				weight_reg[i] <= '0;
			for (int i = 0; i < CH_NUM; i++)
				bias_reg[i] <= '0;
		end
		else if (capture && state == conv_pkg::LOAD_WEIGHTS)
		begin
			for (int i = 0; i < N_WEIGHTS - 1; i++)
				weight_reg[i] <= weight_reg[i+1];
			weight_reg[N_WEIGHTS-1] <= coef_data;
		end
		else if (capture && state == conv_pkg::LOAD_BIAS)
		begin
			for (int i = 0; i < CH_NUM - 1; i++)
				bias_reg[i] <= bias_reg[i+1];
			bias_reg[CH_NUM-1] <= coef_data;
		end
	end

	always_comb
	begin
		for (int i = 0; i < N_WEIGHTS; i++)
			weights[i*conv_pkg::COEF_W +: conv_pkg::COEF_W] = weight_reg[i];
		for (int i = 0; i < CH_NUM; i++)
			biases[i*conv_pkg::COEF_W +: conv_pkg::COEF_W] = bias_reg[i];
	end

	ack_follows_req: assert property (@(posedge clk) disable iff (rst)
		$rose(coef_ack) |-> $past(coef_req));

	// once loaded the coefficient set is frozen until reset
	frozen_when_loaded: assert property (@(posedge clk) disable iff (rst)
		(state == conv_pkg::LOADED) |=> (state == conv_pkg::LOADED) && !$rose(coef_ack)
			&& $stable(weights) && $stable(biases));

endmodule

// File: hw/pixel_window.sv
`timescale 1ns/100ps

module pixel_window #(
	parameter int IMG_WIDTH = 8
)(
	input  logic                                              clk,
	input  logic                                              rst,
	input  logic                                              pix_req,
	input  conv_pkg::pixel_t                                  pix_data,
	input  logic                                              coef_ready,
	output logic                                              pix_ack,
	output logic                                              pix_accept,
	output logic [conv_pkg::KERNEL_TAPS*conv_pkg::PIXEL_W-1:0] window
);
	// three window registers per row sit in front of each line buffer
	localparam int LB_LEN = IMG_WIDTH - 3;

	conv_pkg::pixel_t line_buf [2][LB_LEN];
	conv_pkg::pixel_t win [conv_pkg::KERNEL_TAPS];
	conv_pkg::pixel_t row_in [3];
	logic             accept;

	// requests wait until all coefficients are in
	assign accept = pix_req && !pix_ack && coef_ready;

	// row 2 is the newest row, row 0 the oldest
	assign row_in[2] = pix_data;
	assign row_in[1] = line_buf[0][LB_LEN-1];
	assign row_in[0] = line_buf[1][LB_LEN-1];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pix_ack <= 1'b0;
			pix_accept <= 1'b0;
		end
		else
		begin
			pix_accept <= accept;
			if (accept)
				pix_ack <= 1'b1;
			else if (!pix_req)
				pix_ack <= 1'b0;
		end
	end

	// tap index is row*3+col, col 0 holds the oldest pixel of that row
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++)
				win[t] <= '0;
		end
		else if (accept)
		begin
			for (int r = 0; r < 3; r++)
			begin
				win[r*3+2] <= row_in[r];
				win[r*3+1] <= win[r*3+2];
				win[r*3] <= win[r*3+1];
			end
		end
	end

	// line buffers fed from the oldest register of the row below
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			line_buf[0][0] <= win[6];
			line_buf[1][0] <= win[3];
			for (int i = 1; i < LB_LEN; i++)
			begin
				line_buf[0][i] <= line_buf[0][i-1];
				line_buf[1][i] <= line_buf[1][i-1];
			end
		end
	end

	always_comb
	begin
		for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++)
			window[t*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] = win[t];
	end

	no_grant_before_coefs: assert property (@(posedge clk) disable iff (rst)
		$rose(pix_ack) |-> $past(coef_ready));

	single_cycle_accept: assert property (@(posedge clk) disable iff (rst)
		pix_accept |=> !pix_accept);

endmodule

// File: hw/conv_mac.sv
`timescale 1ns/100ps

module conv_mac #(
	parameter int CH_NUM = 2
)(
	input  logic                                                     clk,
	input  logic                                                     rst,
	input  logic [conv_pkg::KERNEL_TAPS*conv_pkg::PIXEL_W-1:0]        window,
	input  logic [CH_NUM*conv_pkg::KERNEL_TAPS*conv_pkg::COEF_W-1:0]  weights,
	input  logic [CH_NUM*conv_pkg::COEF_W-1:0]                        biases,
	output logic [CH_NUM*conv_pkg::ACC_W-1:0]                         result_data
);
	localparam int PW = conv_pkg::PIXEL_W;
	localparam int CW = conv_pkg::COEF_W;
	localparam int TAPS = conv_pkg::KERNEL_TAPS;

	genvar ch;
	generate
		for (ch = 0; ch < CH_NUM; ch++)
		begin : g_ch
			conv_pkg::acc_t prod [TAPS];
			conv_pkg::acc_t lvl1 [4];
			conv_pkg::acc_t lvl2 [2];
			conv_pkg::acc_t sum;

			always_comb
			begin
				// zero-extend the pixel so it multiplies as a positive value
				for (int t = 0; t < TAPS; t++)
					prod[t] = $signed({1'b0, window[t*PW +: PW]})
						* $signed(weights[(ch*TAPS + t)*CW +: CW]);
				for (int i = 0; i < 4; i++)
					lvl1[i] = prod[2*i] + prod[2*i+1];
				lvl2[0] = lvl1[0] + lvl1[1];
				lvl2[1] = lvl1[2] + lvl1[3];
				// ninth tap and bias join at the root
				sum = lvl2[0] + lvl2[1] + prod[8] + $signed(biases[ch*CW +: CW]);
			end

			always_ff @(posedge clk or posedge rst)
			begin
				if (rst)
					result_data[ch*conv_pkg::ACC_W +: conv_pkg::ACC_W] <= '0;
				else
					result_data[ch*conv_pkg::ACC_W +: conv_pkg::ACC_W] <= sum;
			end
		end
	endgenerate

endmodule

// File: hw/result_tracker.sv
`timescale 1ns/100ps

module result_tracker #(
	parameter int IMG_WIDTH = 8,
	parameter int IMG_HEIGHT = 6
)(
	input  logic           clk,
	input  logic           rst,
	input  logic           pix_accept,
	output logic           result_valid,
	output conv_pkg::pos_t result_row,
	output conv_pkg::pos_t result_col,
	output logic           frame_done
);
	// position of the next pixel to arrive
	conv_pkg::pos_t in_row;
	conv_pkg::pos_t in_col;
	logic           last_col;
	logic           last_row;
	logic           full_window;

	assign last_col = (in_col == conv_pkg::pos_t'(IMG_WIDTH - 1));
	assign last_row = (in_row == conv_pkg::pos_t'(IMG_HEIGHT - 1));

	// a full 3x3 window exists once two rows and two columns are behind
	assign full_window = (in_row >= conv_pkg::pos_t'(2)) && (in_col >= conv_pkg::pos_t'(2));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			in_row <= '0;
			in_col <= '0;
		end
		else if (pix_accept)
		begin
			if (last_col)
			begin
				in_col <= '0;
				if (last_row)
					in_row <= '0;
				else
					in_row <= in_row + 1'b1;
			end
			else
				in_col <= in_col + 1'b1;
		end
	end

	// strobe lines up with the registered MAC output
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			result_valid <= 1'b0;
			frame_done <= 1'b0;
			result_row <= '0;
			result_col <= '0;
		end
		else
		begin
			result_valid <= pix_accept && full_window;
			frame_done <= pix_accept && last_row && last_col;
			if (pix_accept)
			begin
				// top-left corner of the window
				result_row <= in_row - conv_pkg::pos_t'(2);
				result_col <= in_col - conv_pkg::pos_t'(2);
			end
		end
	end

	done_with_result: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> result_valid);

endmodule

// File: hw/conv_top.sv
`timescale 1ns/100ps

module conv_top #(
	parameter int IMG_WIDTH = 8,
	parameter int IMG_HEIGHT = 6,
	parameter int CH_NUM = 2
)(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                coef_req,
	input  conv_pkg::coef_t                     coef_data,
	input  logic                                pix_req,
	input  conv_pkg::pixel_t                    pix_data,
	output logic                                coef_ack,
	output logic                                pix_ack,
	output logic                                coef_ready,
	output logic [CH_NUM*conv_pkg::ACC_W-1:0]   result_data,
	output logic                                result_valid,
	output conv_pkg::pos_t                      result_row,
	output conv_pkg::pos_t                      result_col,
	output logic                                frame_done
);
	logic [CH_NUM*conv_pkg::KERNEL_TAPS*conv_pkg::COEF_W-1:0] weights;
	logic [CH_NUM*conv_pkg::COEF_W-1:0]                        biases;
	logic [conv_pkg::KERNEL_TAPS*conv_pkg::PIXEL_W-1:0]        window;
	logic                                                      pix_accept;

	coef_loader #(
		.CH_NUM(CH_NUM)
	) u_coef_loader (
		.clk(clk),
		.rst(rst),
		.coef_req(coef_req),
		.coef_data(coef_data),
		.coef_ack(coef_ack),
		.coef_ready(coef_ready),
		.weights(weights),
		.biases(biases)
	);

	pixel_window #(
		.IMG_WIDTH(IMG_WIDTH)
	) u_pixel_window (
		.clk(clk),
		.rst(rst),
		.pix_req(pix_req),
		.pix_data(pix_data),
		.coef_ready(coef_ready),
		.pix_ack(pix_ack),
		.pix_accept(pix_accept),
		.window(window)
	);

	conv_mac #(
		.CH_NUM(CH_NUM)
	) u_conv_mac (
		.clk(clk),
		.rst(rst),
		.window(window),
		.weights(weights),
		.biases(biases),
		.result_data(result_data)
	);

	result_tracker #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT)
	) u_result_tracker (
		.clk(clk),
		.rst(rst),
		.pix_accept(pix_accept),
		.result_valid(result_valid),
		.result_row(result_row),
		.result_col(result_col),
		.frame_done(frame_done)
	);

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
	parameter int PERIOD = 20,
	parameter int RST_CYCLES = 10
)(
	input  logic rst_req,
	output logic clk,
	output logic rst
);
	int rst_cnt = 0;

	initial
		clk = 1'b0;

	always #(PERIOD/2) clk = ~clk;

	// reset held for RST_CYCLES rising edges, restarted by rst_req
	always @(posedge clk)
	begin
		if (rst_req)
			rst_cnt <= 0;
		else if (rst_cnt < RST_CYCLES)
			rst_cnt <= rst_cnt + 1;
	end

	assign rst = (rst_cnt < RST_CYCLES);

endmodule

// File: bench/conv_tb.sv
`timescale 1ns/100ps

module conv_tb;
	localparam int IMG_WIDTH = 8;
	localparam int IMG_HEIGHT = 6;
	localparam int CH_NUM = 2;
	localparam int TAPS = conv_pkg::KERNEL_TAPS;
	localparam int N_COEFS = CH_NUM * TAPS + CH_NUM;
	localparam int N_ENTRIES = 4;
	localparam int WIN_PER_FRAME = (IMG_HEIGHT - 2) * (IMG_WIDTH - 2);

	logic                              clk;
	logic                              rst;
	logic                              rst_req;
	logic                              coef_req;
	conv_pkg::coef_t                   coef_data;
	logic                              pix_req;
	conv_pkg::pixel_t                  pix_data;
	logic                              coef_ack;
	logic                              pix_ack;
	logic                              coef_ready;
	logic [CH_NUM*conv_pkg::ACC_W-1:0] result_data;
	logic                              result_valid;
	conv_pkg::pos_t                    result_row;
	conv_pkg::pos_t                    result_col;
	logic                              frame_done;

	// weights channel-major in raster tap order, then one bias per channel
	// an entry without reset keeps the set already loaded
	int coef_tab [N_ENTRIES][N_COEFS] = '{
		'{1, 2, 1, 0, 0, 0, -1, -2, -1,
		  3, -5, 7, -11, 13, -17, 19, -23, 29, 5, -7},
		'{1, 2, 1, 0, 0, 0, -1, -2, -1,
		  3, -5, 7, -11, 13, -17, 19, -23, 29, 5, -7},
		'{127, 127, 127, 127, 127, 127, 127, 127, 127,
		  -128, -128, -128, -128, -128, -128, -128, -128, -128, 127, -128},
		'{-3, 14, -15, 92, -65, 35, -89, 79, -32,
		  38, -46, 26, -43, 38, -32, 79, 50, -28, -1, 100}
	};

	// pattern (0 random, 1 ramp, 2 full scale), frames, max gap, reset first
	int cfg_tab [N_ENTRIES][4] = '{
		'{1, 1, 0, 0},
		'{0, 2, 3, 0},
		'{2, 1, 2, 1},
		'{0, 2, 5, 1}
	};

	int img [2][IMG_HEIGHT][IMG_WIDTH];
	int cur_coef [N_COEFS];
	int cycle_count = 0;
	int cycle_limit = 0;
	int drv_slot = 0;
	bit pix_pending = 1'b0;
	bit ack_prev;
	bit pend;
	int pend_row;
	int pend_col;
	int pend_slot;
	int px_row;
	int px_col;
	int mon_slot;
	int frame_results;
	int total_results = 0;
	int expected_total = 0;

	clk_gen #(
		.PERIOD(20),
		.RST_CYCLES(10)
	) u_clk_gen (.*);

	conv_top u_conv_top (.*);

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("error: %s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	// sum over taps of pixel times weight, plus the channel bias
	function automatic int window_sum(input int slot, input int row, input int col, input int ch);
		int acc;
		acc = cur_coef[CH_NUM*TAPS + ch];
		for (int t = 0; t < TAPS; t++)
			acc += img[slot][row + t/3][col + t%3] * cur_coef[ch*TAPS + t];
		return acc;
	endfunction

	task automatic fill_image(input int slot, input int pattern);
		for (int r = 0; r < IMG_HEIGHT; r++)
			for (int c = 0; c < IMG_WIDTH; c++)
				case (pattern)
				0: img[slot][r][c] = $urandom_range(0, 255);
				1: img[slot][r][c] = ((r * IMG_WIDTH + c) * 5) % 256;
				default: img[slot][r][c] = 255;
				endcase
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_req <= 1'b1;
		@(posedge clk);
		rst_req <= 1'b0;
		do
			@(negedge clk);
		while (rst);
	endtask

	task automatic check_idle();
		assert (!coef_ack) else report_mismatch("coef_ack", coef_ack, 0);
		assert (!pix_ack) else report_mismatch("pix_ack", pix_ack, 0);
		assert (!coef_ready) else report_mismatch("coef_ready", coef_ready, 0);
		assert (!result_valid) else report_mismatch("result_valid", result_valid, 0);
		assert (!frame_done) else report_mismatch("frame_done", frame_done, 0);
	endtask

	task automatic send_coef(input int idx, input int max_gap);
		repeat ($urandom_range(0, max_gap)) @(posedge clk);
		@(posedge clk);
		coef_data <= conv_pkg::coef_t'(cur_coef[idx]);
		coef_req <= 1'b1;
		do
		begin
			@(negedge clk);
			assert (!pix_ack) else abort_run("pix_ack rose before all coefficients were loaded");
		end
		while (!coef_ack);
		// ready exactly on the last handshake
		assert (coef_ready == (idx == N_COEFS - 1))
			else report_mismatch("coef_ready", coef_ready, idx == N_COEFS - 1);
		@(posedge clk);
		coef_req <= 1'b0;
		do
			@(negedge clk);
		while (coef_ack);
	endtask

	task automatic send_pixel(input int r, input int c, input int max_gap);
		if (pix_pending)
			pix_pending = 1'b0;
		else
		begin
			repeat ($urandom_range(0, max_gap)) @(posedge clk);
			@(posedge clk);
			pix_data <= conv_pkg::pixel_t'(img[drv_slot][r][c]);
			pix_req <= 1'b1;
		end
		do
			@(negedge clk);
		while (!pix_ack);
		@(posedge clk);
		pix_req <= 1'b0;
		do
			@(negedge clk);
		while (pix_ack);
	endtask

	task automatic check_result();
		logic                       exp_valid;
		logic                       exp_done;
		logic [conv_pkg::ACC_W-1:0] got;
		int                         exp_sum;
		exp_valid = (pend_row >= 2) && (pend_col >= 2);
		exp_done = exp_valid && (pend_row == IMG_HEIGHT - 1) && (pend_col == IMG_WIDTH - 1);
		assert (result_valid == exp_valid)
			else report_mismatch("result_valid", result_valid, exp_valid);
		assert (frame_done == exp_done) else report_mismatch("frame_done", frame_done, exp_done);
		if (exp_valid)
		begin
			assert (result_row == pend_row - 2)
				else report_mismatch("result_row", result_row, pend_row - 2);
			assert (result_col == pend_col - 2)
				else report_mismatch("result_col", result_col, pend_col - 2);
			for (int ch = 0; ch < CH_NUM; ch++)
			begin
				got = result_data[ch*conv_pkg::ACC_W +: conv_pkg::ACC_W];
				exp_sum = window_sum(pend_slot, pend_row - 2, pend_col - 2, ch);
				assert (got == exp_sum[conv_pkg::ACC_W-1:0])
					else report_mismatch($sformatf("result_data[%0d]", ch), got,
						exp_sum[conv_pkg::ACC_W-1:0]);
			end
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("timeout: run still busy after %0d cycles", cycle_count);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	// result expected one cycle after each rising pix_ack
	always @(negedge clk)
	begin
		if (rst)
		begin
			ack_prev = 1'b0;
			pend = 1'b0;
			px_row = 0;
			px_col = 0;
			mon_slot = 0;
			frame_results = 0;
		end
		else
		begin
			if (pend)
				check_result();
			else
			begin
				assert (!result_valid) else abort_run("result_valid without a pixel accepted");
				assert (!frame_done) else abort_run("frame_done without a pixel accepted");
			end
			// results counted from the DUT strobes, closed by its frame_done
			if (result_valid)
			begin
				frame_results++;
				total_results++;
			end
			if (frame_done)
			begin
				assert (frame_results == WIN_PER_FRAME)
					else report_mismatch("results per frame", frame_results, WIN_PER_FRAME);
				frame_results = 0;
			end
			pend = pix_ack && !ack_prev;
			ack_prev = pix_ack;
			if (pend)
			begin
				pend_row = px_row;
				pend_col = px_col;
				pend_slot = mon_slot;
				if (px_col < IMG_WIDTH - 1)
					px_col++;
				else
				begin
					px_col = 0;
					if (px_row < IMG_HEIGHT - 1)
						px_row++;
					else
					begin
						px_row = 0;
						mon_slot = 1 - mon_slot;
					end
				end
			end
		end
	end

	initial
	begin
		rst_req <= 1'b0;
		coef_req <= 1'b0;
		coef_data <= '0;
		pix_req <= 1'b0;
		pix_data <= '0;
		void'($urandom(32'ha55e_6cb7));
		for (int e = 0; e < N_ENTRIES; e++)
		begin
			cycle_limit += (N_COEFS + cfg_tab[e][1] * IMG_WIDTH * IMG_HEIGHT)
				* (4 + cfg_tab[e][2]) * 2;
			expected_total += cfg_tab[e][1] * WIN_PER_FRAME;
		end
		cycle_limit += 1000;
		do
			@(negedge clk);
		while (rst);
		for (int e = 0; e < N_ENTRIES; e++)
		begin
			if (e == 0 || cfg_tab[e][3] != 0)
			begin
				if (e != 0)
					apply_reset();
				check_idle();
				cur_coef = coef_tab[e];
				drv_slot = 0;
				fill_image(0, cfg_tab[e][0]);
				// first pixel is requested before the coefficients and must wait
				@(posedge clk);
				pix_data <= conv_pkg::pixel_t'(img[0][0][0]);
				pix_req <= 1'b1;
				pix_pending = 1'b1;
				for (int i = 0; i < N_COEFS; i++)
					send_coef(i, cfg_tab[e][2]);
			end
			for (int f = 0; f < cfg_tab[e][1]; f++)
			begin
				if (!pix_pending)
					fill_image(drv_slot, cfg_tab[e][0]);
				for (int r = 0; r < IMG_HEIGHT; r++)
					for (int c = 0; c < IMG_WIDTH; c++)
						send_pixel(r, c, cfg_tab[e][2]);
				drv_slot = 1 - drv_slot;
			end
		end
		repeat (3) @(negedge clk);
		@(posedge clk);
		if (total_results == expected_total)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("FAILED total results: got 0x%h, expected 0x%h", total_results,
				expected_total);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

endmodule

// File: sim.f
hw/conv_pkg.sv
hw/coef_loader.sv
hw/pixel_window.sv
hw/conv_mac.sv
hw/result_tracker.sv
hw/conv_top.sv
bench/clk_gen.sv
bench/conv_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench and RTL with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module conv_tb -f sim.f -Mdir obj_dir -o conv_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/conv_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0
